/* sw_cfg.svh */
`ifndef SW_CFG_SVH
`define SW_CFG_SVH

// --------------------------------------------------
// Switch sizing
// --------------------------------------------------

// Number of input ports and of output ports
`define SW_NUM_PORTS 4

// Bits needed to name one port
`define SW_PORT_W 2

// Words held by each input buffer, one packet at most
`define SW_BUF_DEPTH 64

// Width of one data word and of the header word
`define SW_WORD_W 16

`endif

/* sw_pkg.sv */
`include "sw_cfg.svh"

package sw_pkg;

    // --------------------------------------------------
    // Packet header, the first word of every packet
    // --------------------------------------------------
    typedef struct packed {
        logic [8:0] length;  // Carried through, not checked
        logic [2:0] prior;   // Larger value wins arbitration
        logic [3:0] dest;    // Out of range values get the packet dropped
    } hdr_t;

    // A buffered word is either the header or plain payload
    typedef union packed {
        hdr_t                  hdr;
        logic [`SW_WORD_W-1:0] raw;
    } word_u;

    // --------------------------------------------------
    // Data beat on the forwarding path
    // --------------------------------------------------
    typedef struct packed {
        logic                  vld;
        logic                  sop;   // Header word of the packet
        logic                  eop;   // Last word of the packet
        logic [`SW_WORD_W-1:0] data;
    } beat_t;

    // Beat driven on an output that nobody owns
    localparam beat_t BEAT_IDLE = '0;

    // --------------------------------------------------
    // Request from an input port to the arbiter
    // --------------------------------------------------
    typedef struct packed {
        logic                  req;    // Four-phase request level
        logic [`SW_PORT_W-1:0] dest;   // Output wanted, held while req is high
        logic [2:0]            prior;
    } req_t;

endpackage

/* sw_in_port.sv */
`include "sw_cfg.svh"

module sw_in_port (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  wr_sop,
    input  logic                  wr_eop,
    input  logic                  wr_vld,
    input  logic [`SW_WORD_W-1:0] wr_data,
    output logic                  wr_rdy,
    output sw_pkg::req_t          req,
    input  logic                  ack,
    output sw_pkg::beat_t         beat,
    input  logic                  stop,
    output logic                  drop
);

    localparam int PTR_W = $clog2(`SW_BUF_DEPTH);

    typedef enum logic [2:0] {
        S_RECV,   // Taking words from the source
        S_DROP,   // One cycle while the bad packet is discarded
        S_REQ,    // Request raised, waiting for the grant
        S_SEND,   // Streaming the buffer out
        S_LAST,   // Eop beat is on the output
        S_DONE    // Request dropped, waiting for ack to fall
    } state_t;

    state_t state;

    sw_pkg::word_u buf_mem [`SW_BUF_DEPTH];
    sw_pkg::word_u in_word;
    sw_pkg::hdr_t  hdr_q;
    sw_pkg::hdr_t  hdr_now;

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] wr_addr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] end_ptr;

    logic                  wr_fire;
    logic                  bad_dest;
    logic                  rd_last;
    logic                  issue;
    logic                  req_on;
    logic                  beat_vld;
    logic                  beat_sop;
    logic                  beat_eop;
    logic [`SW_WORD_W-1:0] beat_data;

    // --------------------------------------------------
    // Write side
    // --------------------------------------------------
    assign in_word.raw = wr_data;
    assign wr_rdy      = (state == S_RECV);
    assign wr_fire     = wr_vld && wr_rdy;
    assign wr_addr     = wr_sop ? '0 : wr_ptr;  // Header always lands at address 0

    // A one-word packet has its header on the eop word itself
    assign hdr_now  = wr_sop ? in_word.hdr : hdr_q;
    assign bad_dest = hdr_now.dest >= 4'(`SW_NUM_PORTS);

    always_ff @(posedge clk) begin
        if (wr_fire) begin
            buf_mem[wr_addr] <= in_word;
            if (wr_sop) begin
                hdr_q <= in_word.hdr;   // Decoded one cycle after the header
            end
            if (wr_eop) begin
                end_ptr <= wr_addr;
            end
        end
    end

    // --------------------------------------------------
    // Read side
    // --------------------------------------------------
    assign rd_last = (rd_ptr == end_ptr);

    // A beat is issued only on edges where the output is not stopped
    assign issue = !stop && ((state == S_REQ && ack) || state == S_SEND);

    always_ff @(posedge clk) begin
        if (issue) begin
            beat_data <= buf_mem[rd_ptr].raw;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= S_RECV;
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            req_on   <= 1'b0;
            drop     <= 1'b0;
            beat_vld <= 1'b0;
            beat_sop <= 1'b0;
            beat_eop <= 1'b0;
        end else begin
            drop     <= 1'b0;
            beat_vld <= issue;
            beat_sop <= issue && (state == S_REQ);  // First beat carries the header
            beat_eop <= issue && rd_last;
            if (wr_fire) begin
                wr_ptr <= wr_addr + 1'b1;
            end
            if (issue) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case (state)
                S_RECV: begin
                    if (wr_fire && wr_eop) begin
                        if (bad_dest) begin
                            drop  <= 1'b1;
                            state <= S_DROP;
                        end else begin
                            req_on <= 1'b1;
                            rd_ptr <= '0;
                            state  <= S_REQ;
                        end
                    end
                end
                S_DROP: state <= S_RECV;
                S_REQ: begin
                    if (issue) begin
                        state <= rd_last ? S_LAST : S_SEND;
                    end
                end
                S_SEND: begin
                    if (issue && rd_last) begin
                        state <= S_LAST;
                    end
                end
                S_LAST: begin
                    req_on <= 1'b0;   // Phase three of the handshake
                    state  <= S_DONE;
                end
                S_DONE: begin
                    if (!ack) begin
                        state <= S_RECV;
                    end
                end
                default: state <= S_RECV;
            endcase
        end
    end

    assign req = '{req: req_on, dest: hdr_q.dest[`SW_PORT_W-1:0], prior: hdr_q.prior};

    assign beat = '{vld: beat_vld, sop: beat_sop, eop: beat_eop, data: beat_data};

endmodule

/* sw_arbiter.sv */
`include "sw_cfg.svh"

module sw_arbiter (
    input  logic                     clk,
    input  logic                     rst,
    input  sw_pkg::req_t             req   [`SW_NUM_PORTS],
    output logic [`SW_NUM_PORTS-1:0] ack,
    output logic [`SW_PORT_W-1:0]    owner [`SW_NUM_PORTS],
    output logic [`SW_NUM_PORTS-1:0] owned
);

    // Winner for each output among the ports asking for it
    logic [`SW_NUM_PORTS-1:0] sel_vld;
    logic [`SW_PORT_W-1:0]    sel_idx   [`SW_NUM_PORTS];
    logic [2:0]               sel_prior [`SW_NUM_PORTS];

    // --------------------------------------------------
    // Priority pick per output
    // --------------------------------------------------
    always_comb begin
        for (int o = 0; o < `SW_NUM_PORTS; o++) begin
            sel_vld[o]   = 1'b0;
            sel_idx[o]   = '0;
            sel_prior[o] = '0;
            // Ports are scanned from index 0 up, so a tie keeps the lower index
            for (int p = 0; p < `SW_NUM_PORTS; p++) begin
                if (req[p].req && !ack[p] && req[p].dest == `SW_PORT_W'(o)) begin
                    if (!sel_vld[o] || req[p].prior > sel_prior[o]) begin
                        sel_vld[o]   = 1'b1;
                        sel_idx[o]   = `SW_PORT_W'(p);
                        sel_prior[o] = req[p].prior;
                    end
                end
            end
        end
    end

    // --------------------------------------------------
    // Ownership and the four-phase ack
    // --------------------------------------------------
    // Each port asks for one output only, so no two outputs touch the same
    // ack bit on the same edge
    always_ff @(posedge clk) begin
        if (rst) begin
            ack   <= '0;
            owned <= '0;
            for (int o = 0; o < `SW_NUM_PORTS; o++) begin
                owner[o] <= '0;
            end
        end else begin
            for (int o = 0; o < `SW_NUM_PORTS; o++) begin
                if (owned[o]) begin
                    // Owner dropped req, so release the output and lower ack
                    if (!req[owner[o]].req) begin
                        owned[o]       <= 1'b0;
                        ack[owner[o]]  <= 1'b0;
                    end
                end else if (sel_vld[o]) begin
                    owned[o]          <= 1'b1;
                    owner[o]          <= sel_idx[o];
                    ack[sel_idx[o]]   <= 1'b1;   // Grant one cycle after req
                end
            end
        end
    end

endmodule

/* sw_crossbar.sv */
`include "sw_cfg.svh"

module sw_crossbar (
    input  sw_pkg::beat_t            in_beat  [`SW_NUM_PORTS],
    input  logic [`SW_PORT_W-1:0]    owner    [`SW_NUM_PORTS],
    input  logic [`SW_NUM_PORTS-1:0] owned,
    input  logic [`SW_NUM_PORTS-1:0] out_stop,
    output sw_pkg::beat_t            out_beat [`SW_NUM_PORTS],
    output logic [`SW_NUM_PORTS-1:0] stop
);

    // --------------------------------------------------
    // Forward path, input beats onto outputs
    // --------------------------------------------------
    always_comb begin
        for (int o = 0; o < `SW_NUM_PORTS; o++) begin
            if (owned[o]) begin
                out_beat[o] = in_beat[owner[o]];
            end else begin
                out_beat[o] = sw_pkg::BEAT_IDLE;   // Nothing valid on a free output
            end
        end
    end

    // --------------------------------------------------
    // Return path, output stop back to the owner
    // --------------------------------------------------
    // An input owns at most one output, so every stop bit has one source
    always_comb begin
        stop = '0;
        for (int o = 0; o < `SW_NUM_PORTS; o++) begin
            if (owned[o]) begin
                stop[owner[o]] = out_stop[o];
            end
        end
    end

endmodule

/* sw_top.sv */
`include "sw_cfg.svh"

module sw_top (
    input  logic                     clk,
    input  logic                     rst,
    input  logic [`SW_NUM_PORTS-1:0] wr_sop,
    input  logic [`SW_NUM_PORTS-1:0] wr_eop,
    input  logic [`SW_NUM_PORTS-1:0] wr_vld,
    input  logic [`SW_WORD_W-1:0]    wr_data  [`SW_NUM_PORTS],
    output logic [`SW_NUM_PORTS-1:0] wr_rdy,
    input  logic [`SW_NUM_PORTS-1:0] out_stop,
    output sw_pkg::beat_t            out_beat [`SW_NUM_PORTS],
    output logic [15:0]              drop_cnt
);

    localparam int SUM_W = $clog2(`SW_NUM_PORTS + 1);

    sw_pkg::req_t             req     [`SW_NUM_PORTS];
    sw_pkg::beat_t            in_beat [`SW_NUM_PORTS];
    logic [`SW_PORT_W-1:0]    owner   [`SW_NUM_PORTS];
    logic [`SW_NUM_PORTS-1:0] ack;
    logic [`SW_NUM_PORTS-1:0] owned;
    logic [`SW_NUM_PORTS-1:0] stop;
    logic [`SW_NUM_PORTS-1:0] drop;
    logic [SUM_W-1:0]         drop_sum;

    for (genvar p = 0; p < `SW_NUM_PORTS; p++) begin : g_port
        sw_in_port u_port (
            .clk     (clk),
            .rst     (rst),
            .wr_sop  (wr_sop[p]),
            .wr_eop  (wr_eop[p]),
            .wr_vld  (wr_vld[p]),
            .wr_data (wr_data[p]),
            .wr_rdy  (wr_rdy[p]),
            .req     (req[p]),
            .ack     (ack[p]),
            .beat    (in_beat[p]),
            .stop    (stop[p]),
            .drop    (drop[p])
        );
    end

    sw_arbiter u_arb (
        .clk   (clk),
        .rst   (rst),
        .req   (req),
        .ack   (ack),
        .owner (owner),
        .owned (owned)
    );

    sw_crossbar u_xbar (
        .in_beat  (in_beat),
        .owner    (owner),
        .owned    (owned),
        .out_stop (out_stop),
        .out_beat (out_beat),
        .stop     (stop)
    );

    // Several ports may drop on the same edge and each one counts
    always_comb begin
        drop_sum = '0;
        for (int p = 0; p < `SW_NUM_PORTS; p++) begin
            drop_sum = drop_sum + SUM_W'(drop[p]);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            drop_cnt <= '0;
        end else begin
            drop_cnt <= drop_cnt + 16'(drop_sum);
        end
    end

endmodule

/* sw_sva.sv */
`include "sw_cfg.svh"

module sw_sva (
    input logic                     clk,
    input logic                     rst,
    input sw_pkg::req_t             req      [`SW_NUM_PORTS],
    input logic [`SW_NUM_PORTS-1:0] ack,
    input sw_pkg::beat_t            out_beat [`SW_NUM_PORTS]
);

    logic [`SW_NUM_PORTS-1:0] in_pkt;         // Output is between a sop and its eop
    int                       fail_cnt = 0;   // Assertion failures so far

    always_ff @(posedge clk) begin
        if (rst) begin
            in_pkt <= '0;
        end else begin
            for (int o = 0; o < `SW_NUM_PORTS; o++) begin
                if (out_beat[o].vld && out_beat[o].eop) begin
                    in_pkt[o] <= 1'b0;
                end else if (out_beat[o].vld && out_beat[o].sop) begin
                    in_pkt[o] <= 1'b1;
                end
            end
        end
    end

    // --------------------------------------------------
    // Four-phase handshake per input port
    // --------------------------------------------------
    for (genvar p = 0; p < `SW_NUM_PORTS; p++) begin : g_port
        a_ack_req: assert property (@(posedge clk) disable iff (rst)
            $rose(ack[p]) |-> req[p].req)
            else begin
                $error("ack of port %0d rose without a request", p);
                fail_cnt++;
            end

        // Dest and prior must hold for as long as the grant is in use
        a_req_stable: assert property (@(posedge clk) disable iff (rst)
            (ack[p] && req[p].req) |-> $stable(req[p]))
            else begin
                $error("request of port %0d changed while granted", p);
                fail_cnt++;
            end
    end

    for (genvar o = 0; o < `SW_NUM_PORTS; o++) begin : g_out
        a_sop_framed: assert property (@(posedge clk) disable iff (rst)
            (out_beat[o].vld && out_beat[o].sop) |-> !in_pkt[o])
            else begin
                $error("output %0d started a packet before the last one ended", o);
                fail_cnt++;
            end
    end

endmodule

bind sw_top sw_sva u_sva (
    .clk      (clk),
    .rst      (rst),
    .req      (req),
    .ack      (ack),
    .out_beat (out_beat)
);

/* tb_sw_top.sv */
`include "sw_cfg.svh"

module tb_sw_top;

    localparam int NP           = `SW_NUM_PORTS;
    localparam int N_TESTS      = 6;
    localparam int CYC_PER_TEST = 2000;

    logic                  clk = 1'b0;
    logic                  rst;
    logic [NP-1:0]         wr_sop;
    logic [NP-1:0]         wr_eop;
    logic [NP-1:0]         wr_vld;
    logic [NP-1:0]         wr_rdy;
    logic [NP-1:0]         out_stop;
    logic [`SW_WORD_W-1:0] wr_data  [NP];
    sw_pkg::beat_t         out_beat [NP];
    logic [15:0]           drop_cnt;

    logic [`SW_WORD_W-1:0] pkt_w [NP][$];   // Packet each port sends next
    sw_pkg::beat_t         exp_w [NP][$];   // Beats per output in arrival order
    sw_pkg::beat_t         got_w [NP][$];

    int seed;
    int errs;
    int tests_failed;
    int exp_drops;
    int sva_fails;
    bit stop_run;

    sw_top dut (
        .clk (clk), .rst (rst), .wr_sop (wr_sop), .wr_eop (wr_eop), .wr_vld (wr_vld),
        .wr_data (wr_data), .wr_rdy (wr_rdy), .out_stop (out_stop),
        .out_beat (out_beat), .drop_cnt (drop_cnt)
    );

    always #50 clk = ~clk;

    initial begin
        repeat (N_TESTS * CYC_PER_TEST) @(posedge clk);
        $display("Timeout, the tests did not finish within %0d cycles", N_TESTS * CYC_PER_TEST);
        $display("sim failed");
        $finish;
    end

    always @(negedge clk) begin   // Output beats are settled at the falling edge
        for (int o = 0; o < NP; o++) begin
            if (!rst && out_beat[o].vld) got_w[o].push_back(out_beat[o]);
        end
    end

    // --------------------------------------------------
    // Compare tasks
    // --------------------------------------------------
    task automatic check_word(input string name, input logic [`SW_WORD_W-1:0] got,
                              input logic [`SW_WORD_W-1:0] exp);
        if (got !== exp) begin
            $display("** Error @ %0t: %s got %h expected %h", $time, name, got, exp);
            errs++;
        end
    endtask

    task automatic check_hdr(input string name, input sw_pkg::hdr_t got, input sw_pkg::hdr_t exp);
        if (got !== exp) begin
            $display("** Error @ %0t: %s got dest %0d prior %0d length %0d expected %0d %0d %0d",
                     $time, name, got.dest, got.prior, got.length, exp.dest, exp.prior, exp.length);
            errs++;
        end
    endtask

    task automatic check_count(input string name, input logic [15:0] got, input logic [15:0] exp);
        if (got !== exp) begin
            $display("** Error @ %0t: %s got %0d expected %0d", $time, name, got, exp);
            errs++;
        end
    endtask

    // --------------------------------------------------
    // Driver and scoreboard helpers
    // --------------------------------------------------
    task automatic build_packet(input int p, input int dest, input int prior, input int n);
        sw_pkg::hdr_t h;
        h.dest   = 4'(dest);
        h.prior  = 3'(prior);
        h.length = 9'(n + 1);   // Header plus payload
        pkt_w[p].delete();
        pkt_w[p].push_back(h);
        for (int i = 0; i < n; i++) pkt_w[p].push_back(16'($random(seed)));
    endtask

    task automatic expect_packet(input int p);
        sw_pkg::hdr_t  h;
        sw_pkg::beat_t b;
        h = pkt_w[p][0];
        for (int i = 0; i < pkt_w[p].size(); i++) begin
            b = '{vld: 1'b1, sop: (i == 0), eop: (i == pkt_w[p].size() - 1), data: pkt_w[p][i]};
            exp_w[int'(h.dest)].push_back(b);
        end
    endtask

    task automatic drive_packet(input int p);
        for (int i = 0; i < pkt_w[p].size(); i++) begin
            wr_vld[p]  <= 1'b1;
            wr_sop[p]  <= (i == 0);
            wr_eop[p]  <= (i == pkt_w[p].size() - 1);
            wr_data[p] <= pkt_w[p][i];
            do @(posedge clk); while (!wr_rdy[p]);   // Word taken on this edge
        end
        wr_vld[p] <= 1'b0;
        wr_sop[p] <= 1'b0;
        wr_eop[p] <= 1'b0;
    endtask

    task automatic wait_outputs(input int limit);
        int cyc;
        bit busy;
        cyc  = 0;
        busy = 1'b1;
        while (busy && cyc < limit) begin
            @(posedge clk);
            cyc++;
            busy = 1'b0;
            for (int o = 0; o < NP; o++) if (got_w[o].size() < exp_w[o].size()) busy = 1'b1;
        end
        if (busy) begin
            $display("Outputs did not deliver the expected packets within %0d cycles", limit);
            errs++;
        end
        repeat (20) @(posedge clk);   // Room for extra beats to show up
    endtask

    task automatic compare_outputs();
        sw_pkg::beat_t g;
        sw_pkg::beat_t e;
        string         name;
        for (int o = 0; o < NP; o++) begin
            name = $sformatf("out_beat[%0d]", o);
            if (got_w[o].size() != exp_w[o].size()) begin
                $display("Output %0d delivered %0d beats where %0d were expected",
                         o, got_w[o].size(), exp_w[o].size());
                errs++;
            end
            for (int i = 0; i < got_w[o].size() && i < exp_w[o].size(); i++) begin
                g = got_w[o][i];
                e = exp_w[o][i];
                if (g.sop !== e.sop || g.eop !== e.eop) begin
                    $display("** Error @ %0t: %s.sop/eop got %b%b expected %b%b",
                             $time, name, g.sop, g.eop, e.sop, e.eop);
                    errs++;
                end
                if (e.sop) check_hdr({name, ".hdr"}, g.data, e.data);
                else       check_word({name, ".data"}, g.data, e.data);
            end
            got_w[o].delete();
            exp_w[o].delete();
        end
    endtask

    task automatic finish_test(input string name, input int base);
        int new_fails;
        new_fails = dut.u_sva.fail_cnt - sva_fails;   // Assertions that fired during this test
        sva_fails = dut.u_sva.fail_cnt;
        errs      = errs + new_fails;
        if (errs != base) tests_failed++;
        $display("test %s: %s, %0d errors", name, (errs == base) ? "ok" : "FAILED", errs - base);
    endtask

    // Blocker holds the output stalled while both contenders queue up behind it
    task automatic contend(input int dest, input int blk, input int pa, input int pri_a,
                           input int pb, input int pri_b);
        out_stop[dest] <= 1'b1;
        build_packet(blk, dest, 7, 12);
        expect_packet(blk);
        drive_packet(blk);
        build_packet(pa, dest, pri_a, 5);
        build_packet(pb, dest, pri_b, 7);
        fork
            drive_packet(pa);
            drive_packet(pb);
        join
        repeat (3) @(posedge clk);
        out_stop[dest] <= 1'b0;
        if (pri_a > pri_b || (pri_a == pri_b && pa < pb)) begin
            expect_packet(pa);
            expect_packet(pb);
        end else begin
            expect_packet(pb);
            expect_packet(pa);
        end
        wait_outputs(400);
        compare_outputs();
    endtask

    task automatic send_pair(input int p);
        build_packet(p, (p + 2) % NP, p, 6 + p);
        expect_packet(p);
        drive_packet(p);
        build_packet(p, (p + 2) % NP, p, 3);
        expect_packet(p);
        drive_packet(p);
    endtask

    // --------------------------------------------------
    // Directed tests
    // --------------------------------------------------
    task automatic test_single();
        int base;
        base = errs;
        for (int o = 0; o < NP; o++) begin   // Output 0 gets a header-only packet
            build_packet((o + 1) % NP, o, 2 * o, 5 * o);
            expect_packet((o + 1) % NP);
            drive_packet((o + 1) % NP);
        end
        wait_outputs(400);
        compare_outputs();
        finish_test("single", base);
    endtask

    task automatic test_priority();
        int base;
        base = errs;
        contend(2, 3, 0, 1, 1, 5);
        finish_test("priority", base);
    endtask

    task automatic test_tie();
        int base;
        base = errs;
        contend(0, 1, 3, 4, 2, 4);
        finish_test("tie", base);
    endtask

    task automatic test_parallel();
        int base;
        base = errs;
        fork
            send_pair(0);
            send_pair(1);
            send_pair(2);
            send_pair(3);
        join
        wait_outputs(400);
        compare_outputs();
        finish_test("parallel", base);
    endtask

    task automatic test_stop();
        int base;
        base     = errs;
        stop_run = 1'b1;
        build_packet(0, 1, 3, 40);
        expect_packet(0);
        fork
            begin
                drive_packet(0);
                wait_outputs(600);
                stop_run = 1'b0;
            end
            begin
                while (stop_run) begin
                    @(posedge clk);
                    out_stop[1] <= 1'($random(seed));
                end
                out_stop[1] <= 1'b0;
            end
        join
        compare_outputs();
        finish_test("stop", base);
    endtask

    task automatic test_drop();
        int base;
        int cyc;
        base = errs;
        build_packet(2, 4, 3, 4);
        drive_packet(2);
        exp_drops++;
        cyc = 0;
        do begin
            @(posedge clk);
            cyc++;
        end while (!wr_rdy[2] && cyc < 100);
        if (!wr_rdy[2]) begin
            $display("wr_rdy of port 2 stayed low after the dropped packet");
            errs++;
        end
        @(negedge clk);
        check_count("drop_cnt", drop_cnt, 16'(exp_drops));
        @(posedge clk);
        wait_outputs(50);
        compare_outputs();
        finish_test("drop", base);
    endtask

    initial begin
        seed      = 32'h2c0e;
        sva_fails = 0;
        rst      <= 1'b1;
        wr_sop   <= '0;
        wr_eop   <= '0;
        wr_vld   <= '0;
        out_stop <= '0;
        for (int i = 0; i < NP; i++) wr_data[i] <= '0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        test_single();
        test_priority();
        test_tie();
        test_parallel();
        test_stop();
        test_drop();
        $display("%0d tests, %0d failed, %0d errors", N_TESTS, tests_failed, errs);
        if (errs == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

/* filelist.f */
+incdir+.
sw_pkg.sv
sw_in_port.sv
sw_arbiter.sv
sw_crossbar.sv
sw_top.sv
sw_sva.sv
tb_sw_top.sv

/* Makefile */
VERILATOR = verilator
FLAGS     = --timing --assert
TOP       = tb_sw_top
FILELIST  = filelist.f
OBJ_DIR   = obj_dir
PASS_MSG  = sim passed

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
